// File: verilog.f
hw/mem_word_pkg.sv
hw/mem_op_pkg.sv
hw/mem_bus_if.sv
hw/word_memory.sv
hw/bus_arbiter.sv
hw/port_engine.sv
hw/mem_subsystem_top.sv
tests/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_tb
  import mem_op_pkg::*;
  import mem_word_pkg::*;
  ();

  localparam int addr_width_c = 10;
  localparam int timeout_c    = 200;
  localparam int amo_count_c  = 20;

  typedef struct packed {
    int                      port;
    mem_opcode_e             op;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [mask_width_c-1:0] mask;
    logic [data_width_c-1:0] expected;
  } row_t;

  logic clk   = 1'b0;
  logic reset = 1'b1;

  logic                    p0_v_i      = 1'b0;
  mem_opcode_e             p0_opcode_i = LW;
  logic [addr_width_c-1:0] p0_addr_i   = '0;
  logic [data_width_c-1:0] p0_data_i   = '0;
  logic [mask_width_c-1:0] p0_mask_i   = '0;
  logic                    p0_yumi_i   = 1'b0;
  logic                    p0_ready_o;
  logic                    p0_v_o;
  logic [data_width_c-1:0] p0_data_o;

  logic                    p1_v_i      = 1'b0;
  mem_opcode_e             p1_opcode_i = LW;
  logic [addr_width_c-1:0] p1_addr_i   = '0;
  logic [data_width_c-1:0] p1_data_i   = '0;
  logic [mask_width_c-1:0] p1_mask_i   = '0;
  logic                    p1_yumi_i   = 1'b0;
  logic                    p1_ready_o;
  logic                    p1_v_o;
  logic [data_width_c-1:0] p1_data_o;

  row_t  rows[$];
  string row_names[$];

  int error_count    = 0;
  int mismatch_count = 0;
  int timeout_count  = 0;

  always #50 clk = ~clk;

  mem_subsystem_top #(.addr_width_p(addr_width_c)) u_mem_subsystem_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .p0_v_i      (p0_v_i),
    .p0_opcode_i (p0_opcode_i),
    .p0_addr_i   (p0_addr_i),
    .p0_data_i   (p0_data_i),
    .p0_mask_i   (p0_mask_i),
    .p0_yumi_i   (p0_yumi_i),
    .p0_ready_o  (p0_ready_o),
    .p0_v_o      (p0_v_o),
    .p0_data_o   (p0_data_o),
    .p1_v_i      (p1_v_i),
    .p1_opcode_i (p1_opcode_i),
    .p1_addr_i   (p1_addr_i),
    .p1_data_i   (p1_data_i),
    .p1_mask_i   (p1_mask_i),
    .p1_yumi_i   (p1_yumi_i),
    .p1_ready_o  (p1_ready_o),
    .p1_v_o      (p1_v_o),
    .p1_data_o   (p1_data_o)
  );

  // ##############################
  // Helpers.
  // ##############################

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      error_count++;
      mismatch_count++;
    end
  endtask

  task automatic report_timeout(input string name, input int port, input string what);
    $display("Timeout in %s: port %0d never raised %s", name, port, what);
    error_count++;
    timeout_count++;
  endtask

  function automatic logic ready_of(input int port);
    return (port == 0) ? p0_ready_o : p1_ready_o;
  endfunction

  function automatic logic valid_of(input int port);
    return (port == 0) ? p0_v_o : p1_v_o;
  endfunction

  function automatic logic [31:0] data_of(input int port);
    return (port == 0) ? p0_data_o : p1_data_o;
  endfunction

  task automatic drive_request(input int port, input logic valid, input mem_opcode_e op,
                               input logic [addr_width_c-1:0] addr,
                               input logic [31:0] data, input logic [3:0] mask);
    if (port == 0) begin
      p0_v_i      <= valid;
      p0_opcode_i <= op;
      p0_addr_i   <= addr;
      p0_data_i   <= data;
      p0_mask_i   <= mask;
    end else begin
      p1_v_i      <= valid;
      p1_opcode_i <= op;
      p1_addr_i   <= addr;
      p1_data_i   <= data;
      p1_mask_i   <= mask;
    end
  endtask

  task automatic drive_yumi(input int port, input logic value);
    if (port == 0) begin
      p0_yumi_i <= value;
    end else begin
      p1_yumi_i <= value;
    end
  endtask

  task automatic add_row(input string name, input int port, input mem_opcode_e op,
                         input logic [addr_width_c-1:0] addr, input logic [31:0] data,
                         input logic [3:0] mask, input logic [31:0] expected);
    row_t row;
    row.port     = port;
    row.op       = op;
    row.addr     = addr;
    row.data     = data;
    row.mask     = mask;
    row.expected = expected;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // Sends one packet, waits for its result and consumes it after hold cycles
  // of back-pressure.
  task automatic run_op(input int port, input string name, input mem_opcode_e op,
                        input logic [addr_width_c-1:0] addr, input logic [31:0] data,
                        input logic [3:0] mask, input int hold,
                        output logic [31:0] result);
    int cycles;
    int i;
    result = '0;
    @(posedge clk);
    drive_request(port, 1'b1, op, addr, data, mask);
    cycles = 0;
    @(negedge clk);
    while (!ready_of(port) && cycles < timeout_c) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready_of(port)) begin
      report_timeout(name, port, "ready_o");
      @(posedge clk);
      drive_request(port, 1'b0, op, addr, data, mask);
      return;
    end
    @(posedge clk);
    drive_request(port, 1'b0, op, addr, data, mask);
    cycles = 0;
    @(negedge clk);
    while (!valid_of(port) && cycles < timeout_c) begin
      @(negedge clk);
      cycles++;
    end
    if (!valid_of(port)) begin
      report_timeout(name, port, "v_o");
      return;
    end
    result = data_of(port);
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value({name, " v_o held"}, 32'd1, {31'b0, valid_of(port)});
      check_value({name, " data_o held"}, result, data_of(port));
      check_value({name, " ready_o low"}, 32'd0, {31'b0, ready_of(port)});
    end
    @(posedge clk);
    drive_yumi(port, 1'b1);
    @(posedge clk);
    drive_yumi(port, 1'b0);
  endtask

  // ##############################
  // Stimulus table.
  // ##############################

  task automatic build_table();
    add_row("sw_word",      0, SW,        10'h010, 32'hdead_beef, 4'h0, 32'h0000_0000);
    add_row("lw_word",      1, LW,        10'h010, 32'h0000_0000, 4'h0, 32'hdead_beef);
    // Byte lanes.
    add_row("sb_init",      0, SW,        10'h020, 32'h1122_3344, 4'h0, 32'h0000_0000);
    add_row("sb_lane1",     0, SB,        10'h021, 32'h1234_56a5, 4'h0, 32'h0000_0000);
    add_row("lw_lane1",     0, LW,        10'h020, 32'h0000_0000, 4'h0, 32'h1122_a544);
    add_row("sb_lane3",     1, SB,        10'h023, 32'h0000_007f, 4'h0, 32'h0000_0000);
    add_row("sb_lane0",     1, SB,        10'h020, 32'hffff_ff80, 4'h0, 32'h0000_0000);
    add_row("sb_lane2",     0, SB,        10'h022, 32'h0000_00c3, 4'h0, 32'h0000_0000);
    add_row("lw_all_lanes", 1, LW,        10'h020, 32'h0000_0000, 4'h0, 32'h7fc3_a580);
    add_row("lb_lane0",     0, LB,        10'h020, 32'h0000_0000, 4'h0, 32'hffff_ff80);
    add_row("lbu_lane0",    0, LBU,       10'h020, 32'h0000_0000, 4'h0, 32'h0000_0080);
    add_row("lb_lane1",     1, LB,        10'h021, 32'h0000_0000, 4'h0, 32'hffff_ffa5);
    add_row("lbu_lane2",    1, LBU,       10'h022, 32'h0000_0000, 4'h0, 32'h0000_00c3);
    add_row("lb_lane3",     0, LB,        10'h023, 32'h0000_0000, 4'h0, 32'h0000_007f);
    // Half lanes.
    add_row("sh_init",      0, SW,        10'h030, 32'h0123_4567, 4'h0, 32'h0000_0000);
    add_row("sh_upper",     1, SH,        10'h032, 32'habcd_beef, 4'h0, 32'h0000_0000);
    add_row("lw_upper",     0, LW,        10'h030, 32'h0000_0000, 4'h0, 32'hbeef_4567);
    add_row("sh_lower",     0, SH,        10'h030, 32'h0000_1357, 4'h0, 32'h0000_0000);
    add_row("lw_lower",     1, LW,        10'h030, 32'h0000_0000, 4'h0, 32'hbeef_1357);
    add_row("lh_upper",     0, LH,        10'h032, 32'h0000_0000, 4'h0, 32'hffff_beef);
    add_row("lhu_upper",    1, LHU,       10'h032, 32'h0000_0000, 4'h0, 32'h0000_beef);
    add_row("lh_lower",     1, LH,        10'h030, 32'h0000_0000, 4'h0, 32'h0000_1357);
    add_row("lhu_lower",    0, LHU,       10'h030, 32'h0000_0000, 4'h0, 32'h0000_1357);
    // Masked access.
    add_row("sm_init",      0, SW,        10'h040, 32'haabb_ccdd, 4'h0, 32'h0000_0000);
    add_row("sm_mask5",     1, SM,        10'h040, 32'h1122_3344, 4'h5, 32'h0000_0000);
    add_row("lw_sm",        0, LW,        10'h040, 32'h0000_0000, 4'h0, 32'haa22_cc44);
    add_row("lm_mask9",     1, LM,        10'h040, 32'h0000_0000, 4'h9, 32'haa00_0044);
    add_row("lm_mask6",     0, LM,        10'h040, 32'h0000_0000, 4'h6, 32'h0022_cc00);
    // Atomics return the old word.
    add_row("amo_init",     0, SW,        10'h050, 32'hffff_fff0, 4'h0, 32'h0000_0000);
    add_row("amoswap",      1, AMOSWAP_W, 10'h050, 32'h0000_0005, 4'h0, 32'hffff_fff0);
    add_row("lw_swap",      0, LW,        10'h050, 32'h0000_0000, 4'h0, 32'h0000_0005);
    add_row("amoadd",       0, AMOADD_W,  10'h050, 32'hffff_fff0, 4'h0, 32'h0000_0005);
    add_row("lw_add",       1, LW,        10'h050, 32'h0000_0000, 4'h0, 32'hffff_fff5);
    add_row("amoxor",       1, AMOXOR_W,  10'h050, 32'h0f0f_0f0f, 4'h0, 32'hffff_fff5);
    add_row("lw_xor",       0, LW,        10'h050, 32'h0000_0000, 4'h0, 32'hf0f0_f0fa);
    add_row("amoand",       0, AMOAND_W,  10'h050, 32'hff00_ff00, 4'h0, 32'hf0f0_f0fa);
    add_row("lw_and",       1, LW,        10'h050, 32'h0000_0000, 4'h0, 32'hf000_f000);
    add_row("amoor",        1, AMOOR_W,   10'h050, 32'h000a_000b, 4'h0, 32'hf000_f000);
    add_row("lw_or",        0, LW,        10'h050, 32'h0000_0000, 4'h0, 32'hf00a_f00b);
    add_row("minmax_init",  1, SW,        10'h060, 32'hffff_fff0, 4'h0, 32'h0000_0000);
    add_row("amomin",       0, AMOMIN_W,  10'h060, 32'h0000_0005, 4'h0, 32'hffff_fff0);
    add_row("lw_min",       1, LW,        10'h060, 32'h0000_0000, 4'h0, 32'hffff_fff0);
    add_row("amominu",      1, AMOMINU_W, 10'h060, 32'h0000_0005, 4'h0, 32'hffff_fff0);
    add_row("lw_minu",      0, LW,        10'h060, 32'h0000_0000, 4'h0, 32'h0000_0005);
    add_row("amomax",       0, AMOMAX_W,  10'h060, 32'h8000_0000, 4'h0, 32'h0000_0005);
    add_row("lw_max",       1, LW,        10'h060, 32'h0000_0000, 4'h0, 32'h0000_0005);
    add_row("amomaxu",      1, AMOMAXU_W, 10'h060, 32'h8000_0000, 4'h0, 32'h0000_0005);
    add_row("lw_maxu",      0, LW,        10'h060, 32'h0000_0000, 4'h0, 32'h8000_0000);
    add_row("amomin_neg",   0, AMOMIN_W,  10'h060, 32'h0000_0007, 4'h0, 32'h8000_0000);
    add_row("lw_min_neg",   1, LW,        10'h060, 32'h0000_0000, 4'h0, 32'h8000_0000);
  endtask

  // ##############################
  // Main sequence.
  // ##############################

  initial begin
    logic [31:0] got;
    logic [31:0] start_val;
    logic [31:0] sum;
    logic [31:0] bp_data;
    logic [31:0] old0;
    logic [31:0] old1;
    logic [31:0] add_ops0 [amo_count_c];
    logic [31:0] add_ops1 [amo_count_c];
    logic [31:0] read_words[$];
    logic [31:0] written_words[$];
    int          k0;
    int          k1;
    int          r;

    void'($urandom(32'h4466_0111));
    build_table();

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("reset p0 ready_o", 32'd1, {31'b0, p0_ready_o});
    check_value("reset p1 ready_o", 32'd1, {31'b0, p1_ready_o});
    check_value("reset p0 v_o", 32'd0, {31'b0, p0_v_o});
    check_value("reset p1 v_o", 32'd0, {31'b0, p1_v_o});

    for (r = 0; r < rows.size(); r++) begin
      run_op(rows[r].port, row_names[r], rows[r].op, rows[r].addr, rows[r].data,
             rows[r].mask, 0, got);
      check_value(row_names[r], rows[r].expected, got);
    end

    // Both ports add into one word at the same time.
    start_val = $urandom();
    sum       = start_val;
    for (k0 = 0; k0 < amo_count_c; k0++) begin
      add_ops0[k0] = $urandom();
      add_ops1[k0] = $urandom();
      sum          = sum + add_ops0[k0] + add_ops1[k0];
    end
    run_op(0, "amo_start", SW, 10'h080, start_val, 4'h0, 0, got);
    written_words.push_back(start_val);
    fork
      begin
        for (k0 = 0; k0 < amo_count_c; k0++) begin
          run_op(0, "amo_race_p0", AMOADD_W, 10'h080, add_ops0[k0], 4'h0, 0, old0);
          read_words.push_back(old0);
          written_words.push_back(old0 + add_ops0[k0]);
        end
      end
      begin
        for (k1 = 0; k1 < amo_count_c; k1++) begin
          run_op(1, "amo_race_p1", AMOADD_W, 10'h080, add_ops1[k1], 4'h0, 0, old1);
          read_words.push_back(old1);
          written_words.push_back(old1 + add_ops1[k1]);
        end
      end
    join
    run_op(1, "amo_race_sum", LW, 10'h080, 32'h0, 4'h0, 0, got);
    check_value("amo_race_sum", sum, got);

    // Each add reads the word that the add before it wrote.
    read_words.push_back(got);
    read_words.sort();
    written_words.sort();
    for (r = 0; r < read_words.size(); r++) begin
      check_value("amo_race_old_words", written_words[r], read_words[r]);
    end

    // Back-pressure on results.
    bp_data = $urandom();
    run_op(0, "bp_lw", LW, 10'h010, 32'h0, 4'h0, $urandom_range(8, 1), got);
    check_value("bp_lw", 32'hdead_beef, got);
    run_op(1, "bp_sw", SW, 10'h0a0, bp_data, 4'h0, $urandom_range(8, 1), got);
    check_value("bp_sw", 32'h0000_0000, got);
    run_op(1, "bp_lw2", LW, 10'h0a0, 32'h0, 4'h0, $urandom_range(8, 1), got);
    check_value("bp_lw2", bp_data, got);
    run_op(0, "bp_amoswap", AMOSWAP_W, 10'h0a0, 32'h5a5a_0f0f, 4'h0,
           $urandom_range(8, 1), got);
    check_value("bp_amoswap", bp_data, got);

    $display("Errors: %0d (value mismatches %0d, timeouts %0d)",
             error_count, mismatch_count, timeout_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top
  import mem_op_pkg::*;
  import mem_word_pkg::*;
  #(parameter int addr_width_p = 10)
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    p0_v_i,
    input  mem_opcode_e             p0_opcode_i,
    input  logic [addr_width_p-1:0] p0_addr_i,
    input  logic [data_width_c-1:0] p0_data_i,
    input  logic [mask_width_c-1:0] p0_mask_i,
    input  logic                    p0_yumi_i,
    output logic                    p0_ready_o,
    output logic                    p0_v_o,
    output logic [data_width_c-1:0] p0_data_o,

    input  logic                    p1_v_i,
    input  mem_opcode_e             p1_opcode_i,
    input  logic [addr_width_p-1:0] p1_addr_i,
    input  logic [data_width_c-1:0] p1_data_i,
    input  logic [mask_width_c-1:0] p1_mask_i,
    input  logic                    p1_yumi_i,
    output logic                    p1_ready_o,
    output logic                    p1_v_o,
    output logic [data_width_c-1:0] p1_data_o
  );

  mem_bus_if #(.addr_width_p(addr_width_p)) bus0 ();
  mem_bus_if #(.addr_width_p(addr_width_p)) bus1 ();
  mem_bus_if #(.addr_width_p(addr_width_p)) bus_mem ();

  port_engine #(.addr_width_p(addr_width_p)) u_engine0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (p0_v_i),
    .opcode_i (p0_opcode_i),
    .addr_i   (p0_addr_i),
    .data_i   (p0_data_i),
    .mask_i   (p0_mask_i),
    .ready_o  (p0_ready_o),
    .v_o      (p0_v_o),
    .data_o   (p0_data_o),
    .yumi_i   (p0_yumi_i),
    .bus_o    (bus0.client)
  );

  port_engine #(.addr_width_p(addr_width_p)) u_engine1 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (p1_v_i),
    .opcode_i (p1_opcode_i),
    .addr_i   (p1_addr_i),
    .data_i   (p1_data_i),
    .mask_i   (p1_mask_i),
    .ready_o  (p1_ready_o),
    .v_o      (p1_v_o),
    .data_o   (p1_data_o),
    .yumi_i   (p1_yumi_i),
    .bus_o    (bus1.client)
  );

  bus_arbiter #(.addr_width_p(addr_width_p)) u_arbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cli0_i  (bus0.arbiter),
    .cli1_i  (bus1.arbiter),
    .mem_o   (bus_mem.client)
  );

  word_memory #(.addr_width_p(addr_width_p)) u_memory (
    .clk_i (clk_i),
    .bus_i (bus_mem.memory)
  );

endmodule

`default_nettype wire

// File: hw/port_engine.sv
`timescale 1ns/1ns
`default_nettype none

module port_engine
  import mem_op_pkg::*;
  import mem_word_pkg::*;
  #(parameter int addr_width_p = 10)
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    v_i,
    input  mem_opcode_e             opcode_i,
    input  logic [addr_width_p-1:0] addr_i,
    input  logic [data_width_c-1:0] data_i,
    input  logic [mask_width_c-1:0] mask_i,
    output logic                    ready_o,

    output logic                    v_o,
    output logic [data_width_c-1:0] data_o,
    input  logic                    yumi_i,

    mem_bus_if.client               bus_o
  );

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_wait,
    st_write,
    st_resp
  } state_e;

  state_e state_r, state_n;

  // Accepted packet.
  mem_opcode_e             op_r;
  logic [addr_width_p-1:0] addr_r;
  logic [data_width_c-1:0] data_r;
  logic [mask_width_c-1:0] mask_r;

  // Load value, old word of an atomic, or zero for a store.
  logic [data_width_c-1:0] result_r;

  logic                    accept;
  mem_word_u               store_word;
  logic [mask_width_c-1:0] store_mask;
  mem_word_u               rd_word;
  logic [7:0]              byte_sel;
  logic [15:0]             half_sel;
  logic [data_width_c-1:0] load_mask;
  logic [data_width_c-1:0] load_word;
  logic [data_width_c-1:0] amo_word;

  assign accept  = v_i & ready_o;
  assign ready_o = (state_r == st_idle);
  assign v_o     = (state_r == st_resp);
  assign data_o  = result_r;

  // ##############################
  // State machine.
  // ##############################

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (v_i) begin
          state_n = is_store(opcode_i) ? st_write : st_read;
        end
      end
      st_read: begin
        if (bus_o.gnt) begin
          state_n = st_wait;
        end
      end
      st_wait: begin
        state_n = is_atomic(op_r) ? st_write : st_resp;
      end
      st_write: begin
        if (bus_o.gnt) begin
          state_n = st_resp;
        end
      end
      st_resp: begin
        if (yumi_i) begin
          state_n = st_idle;
        end
      end
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r   <= opcode_i;
      addr_r <= addr_i;
      data_r <= data_i;
      mask_r <= mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_r <= '0;
    end else if (state_r == st_wait) begin
      result_r <= is_atomic(op_r) ? bus_o.rdata : load_word;
    end
  end

  // ##############################
  // Store lanes.
  // ##############################

  always_comb begin
    store_word = data_r;
    store_mask = mask_r;
    case (op_r)
      SW: store_mask = '1;
      SH: begin
        store_word.halves = {2{data_r[15:0]}};
        store_mask        = 4'b0011 << {addr_r[1], 1'b0};
      end
      SB: begin
        store_word.bytes = {4{data_r[7:0]}};
        store_mask       = 4'b0001 << addr_r[1:0];
      end
      default: store_mask = mask_r;
    endcase
  end

  // ##############################
  // Load extraction.
  // ##############################

  assign rd_word  = bus_o.rdata;
  assign byte_sel = rd_word.bytes[addr_r[1:0]];
  assign half_sel = rd_word.halves[addr_r[1]];

  always_comb begin
    for (int i = 0; i < mask_width_c; i++) begin
      load_mask[8*i+:8] = {8{mask_r[i]}};
    end
  end

  always_comb begin
    case (op_r)
      LW:      load_word = bus_o.rdata;
      LH:      load_word = {{16{half_sel[15]}}, half_sel};
      LB:      load_word = {{24{byte_sel[7]}}, byte_sel};
      LHU:     load_word = {16'b0, half_sel};
      LBU:     load_word = {24'b0, byte_sel};
      LM:      load_word = bus_o.rdata & load_mask;
      default: load_word = '0;
    endcase
  end

  // ##############################
  // Atomic update.
  // ##############################

  // The old word sits in result_r once the read returns.
  always_comb begin
    case (op_r)
      AMOSWAP_W: amo_word = data_r;
      AMOADD_W:  amo_word = data_r + result_r;
      AMOXOR_W:  amo_word = data_r ^ result_r;
      AMOAND_W:  amo_word = data_r & result_r;
      AMOOR_W:   amo_word = data_r | result_r;
      AMOMIN_W:  amo_word = ($signed(data_r) < $signed(result_r)) ? data_r : result_r;
      AMOMAX_W:  amo_word = ($signed(data_r) > $signed(result_r)) ? data_r : result_r;
      AMOMINU_W: amo_word = (data_r < result_r) ? data_r : result_r;
      AMOMAXU_W: amo_word = (data_r > result_r) ? data_r : result_r;
      default:   amo_word = result_r;
    endcase
  end

  // ##############################
  // Bus side.
  // ##############################

  assign bus_o.req   = (state_r == st_read) | (state_r == st_write);
  assign bus_o.we    = (state_r == st_write);
  // Lock spans the read, the gap and the write of an atomic.
  assign bus_o.lock  = is_atomic(op_r)
                       & ((state_r == st_read) | (state_r == st_wait)
                          | (state_r == st_write));
  assign bus_o.addr  = addr_r[addr_width_p-1:2];
  assign bus_o.wdata = is_atomic(op_r) ? amo_word : store_word;
  assign bus_o.wmask = is_atomic(op_r) ? '1 : store_mask;

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
  import mem_word_pkg::*;
  #(parameter int addr_width_p = 10)
  (
    input  logic        clk_i,
    input  logic        reset_i,
    mem_bus_if.arbiter  cli0_i,
    mem_bus_if.arbiter  cli1_i,
    mem_bus_if.client   mem_o
  );

  // Priority bit set means client 1 wins a tie.
  logic prio_r;
  logic lock_v_r;
  logic lock_owner_r;

  logic hold;
  logic sel;
  logic granted;

  logic                    sel_we;
  logic                    sel_lock;
  logic [addr_width_p-3:0] sel_addr;
  logic [data_width_c-1:0] sel_wdata;
  logic [mask_width_c-1:0] sel_wmask;

  // The lock holds only while its owner keeps lock raised.
  assign hold = lock_v_r & (lock_owner_r ? cli1_i.lock : cli0_i.lock);

  always_comb begin
    if (hold) begin
      sel = lock_owner_r;
    end else if (cli0_i.req & cli1_i.req) begin
      sel = prio_r;
    end else begin
      sel = cli1_i.req;
    end
  end

  always_comb begin
    if (sel) begin
      sel_we    = cli1_i.we;
      sel_lock  = cli1_i.lock;
      sel_addr  = cli1_i.addr;
      sel_wdata = cli1_i.wdata;
      sel_wmask = cli1_i.wmask;
    end else begin
      sel_we    = cli0_i.we;
      sel_lock  = cli0_i.lock;
      sel_addr  = cli0_i.addr;
      sel_wdata = cli0_i.wdata;
      sel_wmask = cli0_i.wmask;
    end
  end

  assign mem_o.req   = sel ? cli1_i.req : cli0_i.req;
  assign mem_o.we    = sel_we;
  assign mem_o.lock  = sel_lock;
  assign mem_o.addr  = sel_addr;
  assign mem_o.wdata = sel_wdata;
  assign mem_o.wmask = sel_wmask;

  assign granted    = mem_o.req & mem_o.gnt;
  assign cli0_i.gnt = granted & ~sel;
  assign cli1_i.gnt = granted & sel;

  assign cli0_i.rdata = mem_o.rdata;
  assign cli1_i.rdata = mem_o.rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_r       <= 1'b0;
      lock_v_r     <= 1'b0;
      lock_owner_r <= 1'b0;
    end else if (granted) begin
      prio_r       <= ~sel;
      lock_v_r     <= sel_lock;
      lock_owner_r <= sel;
    end else begin
      lock_v_r     <= hold;
    end
  end

endmodule

`default_nettype wire

// File: hw/word_memory.sv
`timescale 1ns/1ns
`default_nettype none

module word_memory
  import mem_word_pkg::*;
  #(parameter int addr_width_p = 10)
  (
    input  logic       clk_i,
    mem_bus_if.memory  bus_i
  );

  localparam int depth_lp = 2 ** (addr_width_p - 2);

  mem_word_u mem_r [depth_lp];
  mem_word_u wr_word;
  mem_word_u rdata_r;

  assign wr_word = bus_i.wdata;

  // Single port, never busy.
  assign bus_i.gnt   = bus_i.req;
  assign bus_i.rdata = rdata_r;

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int i = 0; i < mask_width_c; i++) begin
          if (bus_i.wmask[i]) begin
            mem_r[bus_i.addr].bytes[i] <= wr_word.bytes[i];
          end
        end
      end else begin
        rdata_r <= mem_r[bus_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if
  import mem_word_pkg::*;
  #(parameter int addr_width_p = 10)
  ();

  logic                          req;
  logic                          we;
  logic                          lock;
  // Word address, the byte offset is dropped.
  logic [addr_width_p-3:0]       addr;
  logic [data_width_c-1:0]       wdata;
  logic [mask_width_c-1:0]       wmask;
  logic                          gnt;
  logic [data_width_c-1:0]       rdata;

  modport client (
    output req, we, lock, addr, wdata, wmask,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, lock, addr, wdata, wmask,
    output gnt, rdata
  );

  modport memory (
    input  req, we, addr, wdata, wmask,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// File: hw/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  // ##############################
  // Packet opcodes.
  // ##############################

  typedef enum logic [4:0] {
    LW        = 5'd0,
    LH        = 5'd1,
    LB        = 5'd2,
    LHU       = 5'd3,
    LBU       = 5'd4,
    LM        = 5'd5,
    SW        = 5'd6,
    SH        = 5'd7,
    SB        = 5'd8,
    SM        = 5'd9,
    AMOSWAP_W = 5'd10,
    AMOADD_W  = 5'd11,
    AMOXOR_W  = 5'd12,
    AMOAND_W  = 5'd13,
    AMOOR_W   = 5'd14,
    AMOMIN_W  = 5'd15,
    AMOMAX_W  = 5'd16,
    AMOMINU_W = 5'd17,
    AMOMAXU_W = 5'd18
  } mem_opcode_e;

  // ##############################
  // Opcode classes.
  // ##############################

  function automatic logic is_load(mem_opcode_e op);
    return op inside {LW, LH, LB, LHU, LBU, LM};
  endfunction

  function automatic logic is_store(mem_opcode_e op);
    return op inside {SW, SH, SB, SM};
  endfunction

  // Atomics read then write the same word.
  function automatic logic is_atomic(mem_opcode_e op);
    return op inside {AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
                      AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W};
  endfunction

endpackage

`default_nettype wire

// File: hw/mem_word_pkg.sv
`default_nettype none

package mem_word_pkg;

  // ##############################
  // Data word geometry.
  // ##############################

  localparam int data_width_c = 32;
  localparam int mask_width_c = data_width_c / 8;

  // One memory word, seen as byte lanes or as halfword lanes.
  typedef union packed {
    logic [mask_width_c-1:0][7:0]    bytes;
    logic [mask_width_c/2-1:0][15:0] halves;
  } mem_word_u;

endpackage

`default_nettype wire
